//--- tb_uart_echo.sv
`timescale 1ns/10ps
`include "uart_echo_params.svh"

module tb_uart_echo;

localparam int CLKS = `UART_CLKS_PER_BIT;

logic w_clk;
logic i_nrst;
logic i_rx;
logic o_tx;
logic o_frame_err;
logic o_overflow;

logic [31:0] lfsr;
logic [7:0] rx_q[$];
logic [7:0] exp_q[$];
logic [7:0] last_exp;
logic mon_busy;
logic ovf_seen;
int err_cnt;
int ferr_pulses;
int n_pass;
int n_fail;

uart_echo_top i_uart_echo_top (
    .w_clk       (w_clk),
    .i_nrst      (i_nrst),
    .i_rx        (i_rx),
    .o_tx        (o_tx),
    .o_frame_err (o_frame_err),
    .o_overflow  (o_overflow)
);

initial w_clk = 1'b0;
always #10 w_clk = ~w_clk;

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_bits(input int n, output logic [7:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v = {v[6:0], lfsr[0]};
    end
endtask

task automatic report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, sig, exp, act);
    err_cnt++;
endtask

// One bit period on i_rx, changed just after the clock edge
task automatic drive_bit(input logic v);
    @(posedge w_clk);
    #1 i_rx = v;
    repeat (CLKS - 1) @(posedge w_clk);
endtask

task automatic send_frame(input logic [7:0] b, input logic stop, input int gap_bits);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) begin
        drive_bit(b[i]);
    end
    drive_bit(stop);
    for (i = 0; i < gap_bits; i++) begin
        drive_bit(1'b1);
    end
endtask

// Reference model, a bare LF goes out as CR LF
task automatic send_good(input logic [7:0] b, input int gap_bits);
    send_frame(b, 1'b1, gap_bits);
    if (b == 8'h0A && last_exp != 8'h0D) begin
        exp_q.push_back(8'h0D);
    end
    exp_q.push_back(b);
    last_exp = b;
endtask

task automatic wait_for_bytes(input int n);
    int t;
    t = 0;
    while (rx_q.size() < n && t < (n + 4) * 12 * CLKS) begin
        @(negedge w_clk);
        t++;
    end
    if (rx_q.size() < n) begin
        $display("Timeout at %0t: only %0d of %0d bytes seen on o_tx", $time, rx_q.size(), n);
        err_cnt++;
    end
endtask

// Idle means o_tx high for longer than one frame
task automatic wait_quiet(input int limit);
    int t;
    int idle;
    t = 0;
    idle = 0;
    while (idle < 12 * CLKS && t < limit) begin
        @(negedge w_clk);
        idle = (o_tx === 1'b1 && !mon_busy) ? idle + 1 : 0;
        t++;
    end
    if (idle < 12 * CLKS) begin
        $display("Timeout at %0t: o_tx never returned to idle", $time);
        err_cnt++;
    end
endtask

task automatic check_echo();
    int i;
    wait_for_bytes(exp_q.size());
    wait_quiet(400 * CLKS);
    if (rx_q.size() != exp_q.size()) begin
        report_mismatch("o_tx byte count", exp_q.size(), rx_q.size());
    end else begin
        for (i = 0; i < exp_q.size(); i++) begin
            if (rx_q[i] !== exp_q[i]) begin
                report_mismatch($sformatf("o_tx byte %0d", i), exp_q[i], rx_q[i]);
            end
        end
    end
    rx_q.delete();
    exp_q.delete();
endtask

task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
        n_pass++;
        $display("%s: pass", name);
    end else begin
        n_fail++;
        $display("%s: fail with %0d errors", name, err_cnt - errs_before);
    end
endtask

// Decodes o_tx frames, sampled on the falling edge near bit centres
initial begin : tx_monitor
    logic [7:0] b;
    int i;
    forever begin
        @(negedge w_clk);
        if (i_nrst === 1'b1 && o_tx === 1'b0) begin
            mon_busy = 1'b1;
            repeat (CLKS / 2 - 1) @(negedge w_clk);
            if (o_tx !== 1'b0) begin
                $display("Start bit on o_tx ended early at %0t", $time);
                err_cnt++;
            end
            for (i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge w_clk);
                b[i] = o_tx;
            end
            repeat (CLKS) @(negedge w_clk);
            if (o_tx !== 1'b1) begin
                report_mismatch("o_tx stop bit", 1, o_tx);
            end
            rx_q.push_back(b);
            mon_busy = 1'b0;
        end
    end
end

always @(negedge w_clk) begin
    if (i_nrst === 1'b1 && o_frame_err === 1'b1) begin
        ferr_pulses++;
    end
    // Sticky flag must never drop once set
    if (ovf_seen && o_overflow !== 1'b1) begin
        report_mismatch("o_overflow", 1, o_overflow);
        ovf_seen = 1'b0;
    end else if (o_overflow === 1'b1) begin
        ovf_seen = 1'b1;
    end
end

initial begin : main
    int e;
    int i;
    int t;
    int ferr0;
    logic [7:0] b;
    logic [7:0] g;
    i_rx = 1'b1;
    i_nrst = 1'b0;
    lfsr = 32'h3405_20da;
    last_exp = 8'h00;
    mon_busy = 1'b0;
    ovf_seen = 1'b0;
    err_cnt = 0;
    ferr_pulses = 0;
    n_pass = 0;
    n_fail = 0;
    repeat (8) @(posedge w_clk);
    #1 i_nrst = 1'b1;

    e = err_cnt;
    for (i = 0; i < 20 * CLKS && err_cnt == e; i++) begin
        @(negedge w_clk);
        if (o_tx !== 1'b1) report_mismatch("o_tx", 1, o_tx);
        if (o_frame_err !== 1'b0) report_mismatch("o_frame_err", 0, o_frame_err);
        if (o_overflow !== 1'b0) report_mismatch("o_overflow", 0, o_overflow);
    end
    end_test("reset_idle", e);

    e = err_cnt;
    for (i = 0; i < 30; i++) begin
        b = 8'h0A;
        while (b == 8'h0A) begin
            rand_bits(8, b);
        end
        rand_bits(2, g);
        send_good(b, 3 + g);
    end
    check_echo();
    end_test("random_echo", e);

    // CR LF, LF after a plain byte, then two LFs in a row
    e = err_cnt;
    send_good(8'h41, 4);
    send_good(8'h0D, 4);
    send_good(8'h0A, 4);
    send_good(8'h42, 4);
    send_good(8'h0A, 4);
    send_good(8'h0A, 4);
    send_good(8'h44, 4);
    check_echo();
    end_test("line_endings", e);

    e = err_cnt;
    ferr0 = ferr_pulses;
    send_frame(8'h5A, 1'b0, 4);
    t = 0;
    while (ferr_pulses == ferr0 && t < 2 * CLKS) begin
        @(negedge w_clk);
        t++;
    end
    if (ferr_pulses - ferr0 != 1) report_mismatch("o_frame_err pulses", 1, ferr_pulses - ferr0);
    send_good(8'h55, 4);
    check_echo();
    end_test("framing_error", e);

    // Two output frames per input frame, so the FIFO must fill
    e = err_cnt;
    for (i = 0; i < 40; i++) begin
        send_frame(8'h0A, 1'b1, 0);
    end
    t = 0;
    while (o_overflow !== 1'b1 && t < 2 * CLKS) begin
        @(negedge w_clk);
        t++;
    end
    if (o_overflow !== 1'b1) report_mismatch("o_overflow", 1, o_overflow);
    wait_quiet(400 * CLKS);
    if (rx_q.size() == 0 || rx_q.size() >= 80 || rx_q.size() % 2 != 0) begin
        $display("o_tx carried %0d bytes, not an even count below 80", rx_q.size());
        err_cnt++;
    end
    for (i = 0; i < rx_q.size(); i++) begin
        g = (i % 2 == 0) ? 8'h0D : 8'h0A;
        if (rx_q[i] !== g) report_mismatch($sformatf("o_tx byte %0d", i), g, rx_q[i]);
    end
    end_test("overflow", e);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             n_pass + n_fail, n_pass, n_fail, err_cnt);
    if (err_cnt == 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

//--- uart_byte_fifo.sv
`timescale 1ns/10ps
`include "uart_echo_params.svh"

module uart_byte_fifo (
    input  logic                        w_clk,
    input  logic                        i_nrst,
    input  uart_echo_pkg::byte_strobe_t i_push,
    input  logic                        i_pop,
    output uart_echo_pkg::fifo_head_t   o_head,
    output logic                        o_overflow
);

localparam int DEPTH = `UART_FIFO_DEPTH;
localparam int AW = `UART_FIFO_AW;
localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

logic [7:0] mem [DEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [AW:0] count;
logic empty;
logic full;
logic do_push;
logic do_pop;
logic overflow_q;

// Wrap also works for depths that are not a power of two
function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    if (ptr == LAST_PTR) begin
        return '0;
    end
    return ptr + 1'b1;
endfunction

assign empty = (count == '0);
assign full = (count == FULL_CNT);
assign do_pop = i_pop && !empty;
// A pop in the same cycle frees a slot for the incoming byte
assign do_push = i_push.strobe && (!full || do_pop);

always_ff @(posedge w_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
        overflow_q <= 1'b0;
    end else begin
        if (do_push) begin
            wr_ptr <= ptr_next(wr_ptr);
        end
        if (do_pop) begin
            rd_ptr <= ptr_next(rd_ptr);
        end
        case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
        endcase
        // Byte lost, flag stays set until reset
        if (i_push.strobe && !do_push) begin
            overflow_q <= 1'b1;
        end
    end
end

always_ff @(posedge w_clk) begin
    if (do_push) begin
        mem[wr_ptr] <= i_push.data;
    end
end

assign o_head.empty = empty;
assign o_head.data = mem[rd_ptr];
assign o_overflow = overflow_q;

a_fifo_no_pop_empty: assert property (@(posedge w_clk) disable iff (!i_nrst)
    i_pop |-> !o_head.empty);

endmodule

//--- uart_echo.f
+incdir+.
uart_echo_pkg.sv
uart_rx.sv
uart_byte_fifo.sv
uart_tx.sv
uart_echo_top.sv
tb_uart_echo.sv

//--- uart_echo_params.svh
`ifndef UART_ECHO_PARAMS_SVH
`define UART_ECHO_PARAMS_SVH

// Serial bit period in w_clk cycles
// Kept small so simulation runs fast
`define UART_CLKS_PER_BIT 16

// Echo buffer size in bytes
`define UART_FIFO_DEPTH 8

// Pointer width, must cover UART_FIFO_DEPTH entries
`define UART_FIFO_AW 3

`endif

//--- uart_echo_pkg.sv
package uart_echo_pkg;

// Receiver FSM
typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
} rx_state_e;

// Transmitter FSM
typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_START = 2'd1,
    TX_DATA  = 2'd2,
    TX_STOP  = 2'd3
} tx_state_e;

// Received byte, data valid only while strobe is high
typedef struct packed {
    logic       strobe;
    logic [7:0] data;
} byte_strobe_t;

// FIFO head view, data is meaningless while empty
typedef struct packed {
    logic       empty;
    logic [7:0] data;
} fifo_head_t;

endpackage

//--- uart_echo_top.sv
`timescale 1ns/10ps

module uart_echo_top (
    input  logic w_clk,
    input  logic i_nrst,
    input  logic i_rx,
    output logic o_tx,
    output logic o_frame_err,
    output logic o_overflow
);

uart_echo_pkg::byte_strobe_t w_rx_byte;
uart_echo_pkg::fifo_head_t w_head;
logic w_pop;

// Receiver pushes without back-pressure
uart_rx i_uart_rx (
    .w_clk       (w_clk),
    .i_nrst      (i_nrst),
    .i_rx        (i_rx),
    .o_byte      (w_rx_byte),
    .o_frame_err (o_frame_err)
);

uart_byte_fifo i_uart_byte_fifo (
    .w_clk      (w_clk),
    .i_nrst     (i_nrst),
    .i_push     (w_rx_byte),
    .i_pop      (w_pop),
    .o_head     (w_head),
    .o_overflow (o_overflow)
);

// Transmitter pulls from the FIFO head when idle
uart_tx i_uart_tx (
    .w_clk  (w_clk),
    .i_nrst (i_nrst),
    .i_head (w_head),
    .o_pop  (w_pop),
    .o_tx   (o_tx)
);

endmodule

//--- uart_rx.sv
`timescale 1ns/10ps
`include "uart_echo_params.svh"

module uart_rx (
    input  logic                        w_clk,
    input  logic                        i_nrst,
    input  logic                        i_rx,
    output uart_echo_pkg::byte_strobe_t o_byte,
    output logic                        o_frame_err
);

localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

uart_echo_pkg::rx_state_e state;
logic [CNT_W-1:0] cnt;
logic [2:0] bit_idx;
logic [7:0] shreg;
logic rx_meta;
logic rx_sync;
logic rx_prev;
logic byte_vld;
logic frame_err;
logic bit_end;

// Line idles high, so the synchronizer resets to one
always_ff @(posedge w_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        rx_meta <= 1'b1;
        rx_sync <= 1'b1;
        rx_prev <= 1'b1;
    end else begin
        rx_meta <= i_rx;
        rx_sync <= rx_meta;
        rx_prev <= rx_sync;
    end
end

assign bit_end = (cnt == BIT_LAST);

always_ff @(posedge w_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        state <= uart_echo_pkg::RX_IDLE;
        cnt <= '0;
        bit_idx <= '0;
        byte_vld <= 1'b0;
        frame_err <= 1'b0;
    end else begin
        byte_vld <= 1'b0;
        frame_err <= 1'b0;
        case (state)
        uart_echo_pkg::RX_IDLE: begin
            // Falling edge starts the frame
            if (rx_prev && !rx_sync) begin
                state <= uart_echo_pkg::RX_START;
                cnt <= '0;
            end
        end
        uart_echo_pkg::RX_START: begin
            if (cnt == HALF_LAST) begin
                cnt <= '0;
                bit_idx <= '0;
                // High again at mid start bit means a glitch
                state <= rx_sync ? uart_echo_pkg::RX_IDLE : uart_echo_pkg::RX_DATA;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
        uart_echo_pkg::RX_DATA: begin
            if (bit_end) begin
                cnt <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 3'd7) begin
                    state <= uart_echo_pkg::RX_STOP;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
        uart_echo_pkg::RX_STOP: begin
            if (bit_end) begin
                cnt <= '0;
                byte_vld <= rx_sync;
                frame_err <= !rx_sync;
                state <= uart_echo_pkg::RX_IDLE;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
        default: state <= uart_echo_pkg::RX_IDLE;
        endcase
    end
end

// Data bits arrive LSB first, shift in from the top
always_ff @(posedge w_clk) begin
    if (state == uart_echo_pkg::RX_DATA && bit_end) begin
        shreg <= {rx_sync, shreg[7:1]};
    end
end

assign o_byte.strobe = byte_vld;
assign o_byte.data = shreg;
assign o_frame_err = frame_err;

a_rx_one_outcome: assert property (@(posedge w_clk) disable iff (!i_nrst)
    !(o_byte.strobe && o_frame_err));

a_rx_strobe_single: assert property (@(posedge w_clk) disable iff (!i_nrst)
    o_byte.strobe |=> !o_byte.strobe);

endmodule

//--- uart_tx.sv
`timescale 1ns/10ps
`include "uart_echo_params.svh"

module uart_tx (
    input  logic                      w_clk,
    input  logic                      i_nrst,
    input  uart_echo_pkg::fifo_head_t i_head,
    output logic                      o_pop,
    output logic                      o_tx
);

localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
localparam logic [7:0] CHAR_CR = 8'h0D;
localparam logic [7:0] CHAR_LF = 8'h0A;

uart_echo_pkg::tx_state_e state;
logic [CNT_W-1:0] cnt;
logic [2:0] bit_idx;
logic [7:0] shreg;
logic [7:0] last_byte;
logic lf_pending;
logic tx_q;
logic bit_end;
logic start_frame;
logic insert_cr;
logic tx_shift;

assign bit_end = (cnt == BIT_LAST);
assign start_frame = (state == uart_echo_pkg::TX_IDLE) && !i_head.empty;

// Bare LF at the head, send a CR first and leave the LF in the FIFO
// lf_pending lets the same LF through once the CR is out
assign insert_cr = (i_head.data == CHAR_LF) && (last_byte != CHAR_CR) && !lf_pending;
assign o_pop = start_frame && !insert_cr;

// Next data bit is taken at the end of start and of data bits 0..6
assign tx_shift = bit_end && ((state == uart_echo_pkg::TX_START) ||
                              (state == uart_echo_pkg::TX_DATA && bit_idx != 3'd7));

always_ff @(posedge w_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        state <= uart_echo_pkg::TX_IDLE;
        cnt <= '0;
        bit_idx <= '0;
        last_byte <= '0;
        lf_pending <= 1'b0;
        tx_q <= 1'b1;
    end else begin
        case (state)
        uart_echo_pkg::TX_IDLE: begin
            if (start_frame) begin
                state <= uart_echo_pkg::TX_START;
                cnt <= '0;
                tx_q <= 1'b0;
                if (insert_cr) begin
                    lf_pending <= 1'b1;
                end else begin
                    lf_pending <= 1'b0;
                    last_byte <= i_head.data;
                end
            end
        end
        uart_echo_pkg::TX_START: begin
            if (bit_end) begin
                cnt <= '0;
                bit_idx <= '0;
                tx_q <= shreg[0];
                state <= uart_echo_pkg::TX_DATA;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
        uart_echo_pkg::TX_DATA: begin
            if (bit_end) begin
                cnt <= '0;
                if (bit_idx == 3'd7) begin
                    tx_q <= 1'b1;
                    state <= uart_echo_pkg::TX_STOP;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    tx_q <= shreg[0];
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
        uart_echo_pkg::TX_STOP: begin
            if (bit_end) begin
                cnt <= '0;
                state <= uart_echo_pkg::TX_IDLE;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
        default: state <= uart_echo_pkg::TX_IDLE;
        endcase
    end
end

always_ff @(posedge w_clk) begin
    if (start_frame) begin
        shreg <= insert_cr ? CHAR_CR : i_head.data;
    end else if (tx_shift) begin
        shreg <= {1'b0, shreg[7:1]};
    end
end

assign o_tx = tx_q;

// The start bit follows a pop on the next cycle
a_tx_pop_start: assert property (@(posedge w_clk) disable iff (!i_nrst)
    o_pop |=> (state == uart_echo_pkg::TX_START && !o_tx));

endmodule
